// File: Makefile
# Verilator flow for the raster timing core

TOP = tb_vic_timing
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module vic_timing_top

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log

// File: common/vic_chip_pkg.sv
`default_nettype none

package vic_chip_pkg;

    // Supported chip models
    typedef enum logic [1:0] {
        chip_6567r56a = 2'd0,
        chip_6567r8   = 2'd1,
        chip_6569r1   = 2'd2,
        chip_6569r5   = 2'd3
    } chip_t;

    // Bus cycles per raster line
    localparam logic [6:0] cycles_6567r56a = 7'd64;
    localparam logic [6:0] cycles_6567r8   = 7'd65;
    localparam logic [6:0] cycles_6569     = 7'd63;

    // Raster lines per frame
    localparam logic [8:0] lines_6567r56a = 9'd262;
    localparam logic [8:0] lines_6567r8   = 9'd263;
    localparam logic [8:0] lines_6569     = 9'd312;

    // Last raster_x of a line, eight dots per bus cycle
    localparam logic [9:0] raster_x_max_6567r56a = 10'(8 * cycles_6567r56a - 1);
    localparam logic [9:0] raster_x_max_6567r8   = 10'(8 * cycles_6567r8 - 1);
    localparam logic [9:0] raster_x_max_6569     = 10'(8 * cycles_6569 - 1);

    // Visible xpos values
    localparam logic [9:0] xpos_start_ntsc = 10'h19c;
    localparam logic [9:0] xpos_start_pal  = 10'h194;
    localparam logic [9:0] xpos_jump_ntsc  = 10'h19d;
    localparam logic [9:0] xpos_jump_pal   = 10'h195;
    localparam logic [9:0] xpos_r8_back    = 10'h184;

    // Points within a line where xpos is forced
    localparam logic [6:0] xpos_zero_cycle = 7'd12;
    localparam logic [6:0] xpos_back_cycle = 7'd60;

    // Offset so that sprite 0 fetch lines up with sprite_raster_x of zero
    localparam logic [9:0] sprite_x_start_r8  = 10'd80;
    localparam logic [9:0] sprite_x_start_std = 10'd72;

    function automatic logic [6:0] chip_cycles(chip_t c);
        case (c)
            chip_6567r56a: return cycles_6567r56a;
            chip_6567r8:   return cycles_6567r8;
            default:       return cycles_6569;
        endcase
    endfunction

    function automatic logic [9:0] chip_raster_x_max(chip_t c);
        case (c)
            chip_6567r56a: return raster_x_max_6567r56a;
            chip_6567r8:   return raster_x_max_6567r8;
            default:       return raster_x_max_6569;
        endcase
    endfunction

    function automatic logic [8:0] chip_raster_y_max(chip_t c);
        case (c)
            chip_6567r56a: return lines_6567r56a - 9'd1;
            chip_6567r8:   return lines_6567r8 - 9'd1;
            default:       return lines_6569 - 9'd1;
        endcase
    endfunction

    function automatic logic chip_is_ntsc(chip_t c);
        return (c == chip_6567r56a) || (c == chip_6567r8);
    endfunction

    function automatic logic [9:0] chip_xpos_start(chip_t c);
        return chip_is_ntsc(c) ? xpos_start_ntsc : xpos_start_pal;
    endfunction

    function automatic logic [9:0] chip_xpos_jump(chip_t c);
        return chip_is_ntsc(c) ? xpos_jump_ntsc : xpos_jump_pal;
    endfunction

    function automatic logic [9:0] chip_sprite_x_start(chip_t c);
        return (c == chip_6567r8) ? sprite_x_start_r8 : sprite_x_start_std;
    endfunction

endpackage

`default_nettype wire

// File: common/vic_raster_pkg.sv
`default_nettype none

package vic_raster_pkg;

    // Eight dots of four clk_dot4x ticks make one phi cycle
    localparam int dot4x_per_phi = 32;
    localparam int phi_tick_w    = $clog2(dot4x_per_phi);

    // Registered strobes shared by the whole core
    typedef struct packed {
        logic dot_rising_0;
        logic dot_rising_2;
        logic clk_phi;
        logic phi_end;      // last tick of a phi cycle
    } phase_strobes_t;

    // Raster position, 65 bits
    typedef struct packed {
        logic [9:0]  raster_x;
        logic [10:0] hires_raster_x;
        logic [9:0]  xpos;
        logic [9:0]  sprite_raster_x;
        logic [8:0]  raster_line;
        logic [8:0]  raster_line_d;
        logic [5:0]  blink_ctr;
    } raster_pos_t;

endpackage

`default_nettype wire

// File: logic/dot_phase_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dot_phase_gen
    import vic_raster_pkg::*;
(
    input  wire            clk_dot4x,
    input  wire            rst,
    output phase_strobes_t strobes
);

    logic [phi_tick_w-1:0] tick;
    logic                  tick_last;
    logic                  phi_high;

    assign tick_last = (tick == phi_tick_w'(dot4x_per_phi - 1));

    // Second half of the phi cycle
    assign phi_high = (tick >= phi_tick_w'(dot4x_per_phi / 2));

    // Tick position within one phi cycle
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick <= '0;
        end else if (tick_last) begin
            tick <= '0;
        end else begin
            tick <= tick + 1'b1;
        end
    end

    // Strobes lag the tick count by one clock
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            strobes <= '0;
        end else begin
            // Each dot spans four ticks
            strobes.dot_rising_0 <= (tick[1:0] == 2'd0);
            strobes.dot_rising_2 <= (tick[1:0] == 2'd2);
            strobes.clk_phi      <= phi_high;
            strobes.phi_end      <= tick_last;
        end
    end

endmodule

`default_nettype wire

// File: logic/vic_timing_top.sv
`timescale 1ns/100ps
`default_nettype none

module vic_timing_top
    import vic_chip_pkg::*;
    import vic_raster_pkg::*;
(
    input  wire                 clk_dot4x,
    input  wire                 rst,
    input  wire chip_t          chip,
    output wire phase_strobes_t strobes,
    output wire [6:0]           cycle_num,
    output wire raster_pos_t    pos
);

    // Dot and phi strobes for every counter below
    dot_phase_gen u_dot_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .strobes   (strobes)
    );

    // Bus cycle within the line
    line_cycle_counter u_line_cycle_counter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .strobes   (strobes),
        .cycle_num (cycle_num)
    );

    // Position counters, xpos rules depend on cycle_num
    raster u_raster (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .strobes   (strobes),
        .cycle_num (cycle_num),
        .pos       (pos)
    );

endmodule

`default_nettype wire

// File: raster/line_cycle_counter.sv
`timescale 1ns/100ps
`default_nettype none

module line_cycle_counter
    import vic_chip_pkg::*;
    import vic_raster_pkg::*;
(
    input  wire             clk_dot4x,
    input  wire             rst,
    input  wire chip_t      chip,
    input  wire phase_strobes_t strobes,
    output logic [6:0]      cycle_num
);

    chip_t      chip_r;
    logic [6:0] last_cycle;

    // Chip model is only taken while in reset
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            chip_r <= chip;
        end
    end

    assign last_cycle = chip_cycles(chip_r) - 7'd1;

    // One count per phi cycle
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle_num <= 7'd0;
        end else if (strobes.phi_end) begin
            if (cycle_num == last_cycle) begin
                cycle_num <= 7'd0;
            end else begin
                cycle_num <= cycle_num + 7'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: raster/raster.sv
`timescale 1ns/100ps
`default_nettype none

module raster
    import vic_chip_pkg::*;
    import vic_raster_pkg::*;
(
    input  wire                 clk_dot4x,
    input  wire                 rst,
    input  wire chip_t          chip,
    input  wire phase_strobes_t strobes,
    input  wire [6:0]           cycle_num,
    output raster_pos_t         pos
);

    chip_t       chip_r;

    logic [9:0]  raster_x;
    logic [10:0] hires_raster_x;
    logic [9:0]  xpos;
    logic [9:0]  sprite_raster_x;
    logic [8:0]  raster_line;
    logic [8:0]  raster_line_d;
    logic [5:0]  blink_ctr;

    // Pending updates for the delayed line number
    logic        start_of_line;
    logic        start_of_frame;

    logic [9:0]  raster_x_max;
    logic [8:0]  raster_y_max;
    logic [2:0]  cycle_bit;
    logic        x_wrap;
    logic        y_wrap;
    logic        xpos_jump_pt;
    logic        xpos_zero_pt;
    logic        xpos_back_pt;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            chip_r <= chip;
        end
    end

    assign raster_x_max = chip_raster_x_max(chip_r);
    assign raster_y_max = chip_raster_y_max(chip_r);

    // Pixel within the current bus cycle
    assign cycle_bit = raster_x[2:0];

    assign x_wrap = (raster_x == raster_x_max);
    assign y_wrap = (raster_line == raster_y_max);

    // Special xpos points within the line
    assign xpos_jump_pt = (cycle_num == 7'd0) && (cycle_bit == 3'd0);
    assign xpos_zero_pt = (cycle_num == xpos_zero_cycle) && (cycle_bit == 3'd3);
    // 6567R8 repeats xpos 'h184 around the end of the line
    assign xpos_back_pt = (chip_r == chip_6567r8) &&
                          (((cycle_num == xpos_back_cycle) && (cycle_bit == 3'd7)) ||
                           ((cycle_num == xpos_back_cycle + 7'd1) &&
                            ((cycle_bit == 3'd3) || (cycle_bit == 3'd7))));

    // Raster x, line and blink counters
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= 10'd0;
            raster_line <= 9'd0;
            blink_ctr   <= 6'd0;
        end else if (strobes.dot_rising_0) begin
            if (!x_wrap) begin
                raster_x <= raster_x + 10'd1;
            end else begin
                raster_x <= 10'd0;
                if (!y_wrap) begin
                    raster_line <= raster_line + 9'd1;
                end else begin
                    raster_line <= 9'd0;
                    // Frame count drives the hires blink attribute
                    blink_ctr   <= blink_ctr + 6'd1;
                end
            end
        end
    end

    // Hires x counts half dots
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            hires_raster_x <= 11'd0;
        end else if (strobes.dot_rising_0 && x_wrap) begin
            hires_raster_x <= 11'd0;
        end else if (strobes.dot_rising_0 || strobes.dot_rising_2) begin
            hires_raster_x <= hires_raster_x + 11'd1;
        end
    end

    // Reset values follow the chip input, not the captured copy
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xpos <= chip_xpos_start(chip);
        end else if (strobes.dot_rising_0) begin
            if (x_wrap) begin
                xpos <= chip_xpos_start(chip_r);
            end else if (xpos_jump_pt) begin
                xpos <= chip_xpos_jump(chip_r);
            end else if (xpos_back_pt) begin
                xpos <= xpos_r8_back;
            end else if (xpos_zero_pt) begin
                xpos <= 10'd0;
            end else begin
                xpos <= xpos + 10'd1;
            end
        end
    end

    // Sprite x runs ahead of raster_x so sprite compares never wrap
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            sprite_raster_x <= chip_sprite_x_start(chip);
        end else if (strobes.dot_rising_0) begin
            if (sprite_raster_x == raster_x_max) begin
                sprite_raster_x <= 10'd0;
            end else begin
                sprite_raster_x <= sprite_raster_x + 10'd1;
            end
        end
    end

    // Delayed line number moves in the low phi phase
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_line_d  <= 9'd0;
            start_of_line  <= 1'b0;
            start_of_frame <= 1'b0;
        end else begin
            if (!strobes.clk_phi && start_of_line) begin
                raster_line_d <= raster_line_d + 9'd1;
                start_of_line <= 1'b0;
            end

            // Frame start waits for cycle 1
            if (!strobes.clk_phi && start_of_frame && (cycle_num == 7'd1)) begin
                raster_line_d  <= 9'd0;
                start_of_frame <= 1'b0;
            end

            // New request wins over a clear in the same clock
            if (strobes.dot_rising_0 && x_wrap) begin
                if (!y_wrap) begin
                    start_of_line <= 1'b1;
                end else begin
                    start_of_frame <= 1'b1;
                end
            end
        end
    end

    assign pos = '{
        raster_x:        raster_x,
        hires_raster_x:  hires_raster_x,
        xpos:            xpos,
        sprite_raster_x: sprite_raster_x,
        raster_line:     raster_line,
        raster_line_d:   raster_line_d,
        blink_ctr:       blink_ctr
    };

endmodule

`default_nettype wire

// File: sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One row per chip model, applied in order by the test loop
// Columns: chip, bus cycles per line, lines per frame,
//          xpos start, xpos jump, sprite x offset
typedef struct packed {
    logic [1:0] chip;
    logic [6:0] cycles;
    logic [8:0] lines;
    logic [9:0] xpos_start;
    logic [9:0] xpos_jump;
    logic [9:0] sprite_start;
} chip_vector_t;

localparam int num_vectors = 4;

localparam chip_vector_t vectors [num_vectors] = '{
    // 6567R56A, early NTSC
    '{2'd0, 7'd64, 9'd262, 10'h19c, 10'h19d, 10'd72},
    // 6567R8, NTSC with the 'h184 repeats
    '{2'd1, 7'd65, 9'd263, 10'h19c, 10'h19d, 10'd80},
    // 6569R1, PAL
    '{2'd2, 7'd63, 9'd312, 10'h194, 10'h195, 10'd72},
    // 6569R5, PAL
    '{2'd3, 7'd63, 9'd312, 10'h194, 10'h195, 10'd72}
};

`endif

// File: sim/tb_vic_timing.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vic_timing
    import vic_chip_pkg::*;
    import vic_raster_pkg::*;
();

    `include "tb_vectors.svh"

    localparam int clk_period   = 40;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 4;
    localparam int error_limit  = 50;

    logic           clk_dot4x;
    logic           rst;
    chip_t          chip;
    phase_strobes_t strobes;
    logic [6:0]     cycle_num;
    raster_pos_t    pos;

    int   error_count;
    int   check_count;
    int   cycle_count;
    logic abort;

    // Reference model state mirroring the registers after each clock
    int             tick_next;
    phase_strobes_t m_strobes;
    logic [6:0]     m_cycle;
    logic [9:0]     m_rx;
    logic [10:0]    m_hx;
    logic [9:0]     m_xpos;
    logic [9:0]     m_sx;
    logic [8:0]     m_line;
    logic [8:0]     m_line_d;
    logic [5:0]     m_blink;
    logic           m_line_pend;
    logic           m_frame_pend;

    // Per-row constants
    logic [6:0]     last_cycle;
    logic [9:0]     rx_max;
    logic [8:0]     y_max;
    logic [9:0]     xpos_start;
    logic [9:0]     xpos_jump;
    logic [9:0]     sprite_start;
    logic           is_r8;

    vic_timing_top UUT (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .strobes   (strobes),
        .cycle_num (cycle_num),
        .pos       (pos)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(clk_period / 2) clk_dot4x = ~clk_dot4x;
    end

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    task automatic next_clock();
        @(posedge clk_dot4x);
        #drive_delay;
    endtask

    // Clocks of all rows together including reset
    function automatic int run_length();
        int total;
        total = 0;
        for (int i = 0; i < num_vectors; i++) begin
            total += reset_cycles + (int'(vectors[i].lines) + 2) * int'(vectors[i].cycles)
                     * dot4x_per_phi;
        end
        return total;
    endfunction

    task automatic reset_model(input chip_vector_t v);
        last_cycle   = 7'(int'(v.cycles) - 1);
        rx_max       = 10'(8 * int'(v.cycles) - 1);
        y_max        = 9'(int'(v.lines) - 1);
        xpos_start   = v.xpos_start;
        xpos_jump    = v.xpos_jump;
        sprite_start = v.sprite_start;
        is_r8        = (chip_t'(v.chip) == chip_6567r8);
        tick_next    = 0;
        m_strobes    = '0;
        m_cycle      = 7'd0;
        m_rx         = 10'd0;
        m_hx         = 11'd0;
        m_xpos       = v.xpos_start;
        m_sx         = v.sprite_start;
        m_line       = 9'd0;
        m_line_d     = 9'd0;
        m_blink      = 6'd0;
        m_line_pend  = 1'b0;
        m_frame_pend = 1'b0;
    endtask

    // Next register values from the current ones and the checked strobes
    task automatic advance_model();
        phase_strobes_t s;
        logic           x_wrap;
        logic [2:0]     dot;
        s = strobes;
        x_wrap = (m_rx == rx_max);
        dot = m_rx[2:0];
        if (!s.clk_phi && m_line_pend) begin
            m_line_d    = m_line_d + 9'd1;
            m_line_pend = 1'b0;
        end
        if (!s.clk_phi && m_frame_pend && m_cycle == 7'd1) begin
            m_line_d     = 9'd0;
            m_frame_pend = 1'b0;
        end
        if (s.dot_rising_0) begin
            if (x_wrap) begin
                m_xpos = xpos_start;
            end else if (m_cycle == 7'd0 && dot == 3'd0) begin
                m_xpos = xpos_jump;
            end else if (m_cycle == 7'd12 && dot == 3'd3) begin
                m_xpos = 10'd0;
            end else if (is_r8 && ((m_cycle == 7'd60 && dot == 3'd7) ||
                                   (m_cycle == 7'd61 && (dot == 3'd3 || dot == 3'd7)))) begin
                m_xpos = 10'h184;
            end else begin
                m_xpos = m_xpos + 10'd1;
            end
            m_sx = (m_sx == rx_max) ? 10'd0 : m_sx + 10'd1;
            m_hx = x_wrap ? 11'd0 : m_hx + 11'd1;
            if (x_wrap) begin
                m_rx = 10'd0;
                if (m_line == y_max) begin
                    m_line       = 9'd0;
                    m_blink      = m_blink + 6'd1;
                    m_frame_pend = 1'b1;
                end else begin
                    m_line      = m_line + 9'd1;
                    m_line_pend = 1'b1;
                end
            end else begin
                m_rx = m_rx + 10'd1;
            end
        end else if (s.dot_rising_2) begin
            m_hx = m_hx + 11'd1;
        end
        if (s.phi_end) begin
            m_cycle = (m_cycle == last_cycle) ? 7'd0 : m_cycle + 7'd1;
        end
        // Strobes decode the tick that the phase counter holds now
        m_strobes.dot_rising_0 = (tick_next % 4 == 0);
        m_strobes.dot_rising_2 = (tick_next % 4 == 2);
        m_strobes.clk_phi      = (tick_next >= dot4x_per_phi / 2);
        m_strobes.phi_end      = (tick_next == dot4x_per_phi - 1);
        tick_next = (tick_next + 1) % dot4x_per_phi;
    endtask

    task automatic check_outputs();
        check("dot_rising_0", 16'(m_strobes.dot_rising_0), 16'(strobes.dot_rising_0));
        check("dot_rising_2", 16'(m_strobes.dot_rising_2), 16'(strobes.dot_rising_2));
        check("clk_phi", 16'(m_strobes.clk_phi), 16'(strobes.clk_phi));
        check("phi_end", 16'(m_strobes.phi_end), 16'(strobes.phi_end));
        check("cycle_num", 16'(m_cycle), 16'(cycle_num));
        check("raster_x", 16'(m_rx), 16'(pos.raster_x));
        check("hires_raster_x", 16'(m_hx), 16'(pos.hires_raster_x));
        check("xpos", 16'(m_xpos), 16'(pos.xpos));
        check("sprite_raster_x", 16'(m_sx), 16'(pos.sprite_raster_x));
        check("raster_line", 16'(m_line), 16'(pos.raster_line));
        check("raster_line_d", 16'(m_line_d), 16'(pos.raster_line_d));
        check("blink_ctr", 16'(m_blink), 16'(pos.blink_ctr));
    endtask

    // Relations stated directly by the position rules
    task automatic check_relations();
        int sprite_x;
        sprite_x = (int'(m_rx) + int'(sprite_start)) % (int'(rx_max) + 1);
        check("sprite_raster_x offset", 16'(sprite_x), 16'(pos.sprite_raster_x));
        // Line advance falls in the last bus cycle, the delayed copy follows by cycle 2
        if (m_cycle >= 7'd2 && m_cycle < last_cycle) begin
            check("raster_line_d settled", 16'(m_line), 16'(pos.raster_line_d));
        end
    endtask

    task automatic run_row(input chip_vector_t v);
        int clocks;
        chip = chip_t'(v.chip);
        rst  = 1'b1;
        repeat (reset_cycles) next_clock();
        reset_model(v);
        check_outputs();
        rst = 1'b0;
        // One frame plus two lines
        clocks = (int'(v.lines) + 2) * int'(v.cycles) * dot4x_per_phi;
        for (int n = 0; n < clocks && !abort; n++) begin
            advance_model();
            next_clock();
            check_outputs();
            check_relations();
            if (error_count >= error_limit) begin
                $display("Too many errors, stopping the run early");
                abort = 1'b1;
            end
        end
        if (!abort) begin
            check("raster_line at row end", 16'd2, 16'(pos.raster_line));
            check("blink_ctr at row end", 16'd1, 16'(pos.blink_ctr));
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        rst         = 1'b1;
        chip        = chip_6567r56a;
        error_count = 0;
        check_count = 0;
        abort       = 1'b0;
        for (int i = 0; i < num_vectors && !abort; i++) begin
            run_row(vectors[i]);
        end
        finish_run();
    end

    // Watchdog with a quarter of margin over the full run
    initial begin
        int limit;
        cycle_count = 0;
        limit = run_length() + run_length() / 4;
        while (cycle_count < limit) begin
            @(posedge clk_dot4x);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d clocks", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+sim
common/vic_chip_pkg.sv
common/vic_raster_pkg.sv
logic/dot_phase_gen.sv
raster/line_cycle_counter.sv
raster/raster.sv
logic/vic_timing_top.sv
sim/tb_vic_timing.sv
